// ==== Bender.yml ====
package:
  name: eth_10g_pcs

sources:
  - files:
      - source/pcs_pkg.sv
      - source/pcs_reset_seq.sv
      - source/pcs_tx_path.sv
      - source/pcs_rx_descrambler.sv
      - source/pcs_block_lock.sv
      - source/eth_10g_pcs_top.sv
  - target: test
    files:
      - tests/eth_10g_pcs_assert.sv
      - tests/eth_10g_pcs_tb.sv

// ==== eth_10g_pcs.f ====
source/pcs_pkg.sv
source/pcs_reset_seq.sv
source/pcs_tx_path.sv
source/pcs_rx_descrambler.sv
source/pcs_block_lock.sv
source/eth_10g_pcs_top.sv
tests/eth_10g_pcs_assert.sv
tests/eth_10g_pcs_tb.sv

// ==== source/eth_10g_pcs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_10g_pcs_top #(
    parameter int LOCK_COUNT    = 64,
    parameter int INVALID_LIMIT = 16,
    parameter int SLIP_WAIT     = 32
) (
    input  wire                        clk_gtx_tx,
    input  wire                        i_rst_n,
    // Transceiver status and controls
    input  wire pcs_pkg::gt_status_t   i_gt_status,
    output wire pcs_pkg::gt_ctrl_t     o_gt_ctrl,
    // TX side
    input  wire                        i_tx_gearbox_ready,
    output wire pcs_pkg::pcs_word_t    o_tx_data,
    // RX side
    input  wire pcs_pkg::pcs_rx_word_t i_rx,
    output wire pcs_pkg::pcs_rx_word_t o_rx,
    output wire pcs_pkg::block_type_t  o_block_type,
    output wire                        o_block_lock,
    output wire                        o_rxslip
);

    pcs_reset_seq reset_seq_u (
        .clk_gtx_tx  (clk_gtx_tx),
        .i_rst_n     (i_rst_n),
        .i_gt_status (i_gt_status),
        .o_gt_ctrl   (o_gt_ctrl)
    );

    pcs_tx_path tx_path_u (
        .clk_gtx_tx         (clk_gtx_tx),
        .i_rst_n            (i_rst_n),
        .i_tx_gearbox_ready (i_tx_gearbox_ready),
        .i_tx_seqstart      (o_gt_ctrl.tx_seqstart),
        .o_tx_data          (o_tx_data)
    );

    pcs_rx_descrambler rx_descrambler_u (
        .clk_gtx_tx   (clk_gtx_tx),
        .i_rst_n      (i_rst_n),
        .i_rx         (i_rx),
        .o_rx         (o_rx),
        .o_block_type (o_block_type)
    );

    // Lock watches the raw headers from the transceiver
    pcs_block_lock #(
        .LOCK_COUNT    (LOCK_COUNT),
        .INVALID_LIMIT (INVALID_LIMIT),
        .SLIP_WAIT     (SLIP_WAIT)
    ) block_lock_u (
        .clk_gtx_tx   (clk_gtx_tx),
        .i_rst_n      (i_rst_n),
        .i_rx         (i_rx),
        .o_block_lock (o_block_lock),
        .o_rxslip     (o_rxslip)
    );

endmodule

`default_nettype wire

// ==== source/pcs_block_lock.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcs_block_lock #(
    parameter int LOCK_COUNT    = 64,
    parameter int INVALID_LIMIT = 16,
    parameter int SLIP_WAIT     = 32
) (
    input  wire                        clk_gtx_tx,
    input  wire                        i_rst_n,
    input  wire pcs_pkg::pcs_rx_word_t i_rx,
    output logic                       o_block_lock,
    output logic                       o_rxslip
);

    localparam int CNT_W  = $clog2(LOCK_COUNT + 1);
    localparam int WAIT_W = $clog2(SLIP_WAIT + 1);

    localparam logic [CNT_W-1:0]  SH_LAST   = CNT_W'(LOCK_COUNT - 1);
    localparam logic [CNT_W-1:0]  INV_LAST  = CNT_W'(INVALID_LIMIT - 1);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(SLIP_WAIT - 1);

    typedef enum logic [1:0] {
        UNLOCKED,
        SLIP_WAIT_ST,
        LOCKED
    } lock_state_t;

    lock_state_t       state;
    logic [CNT_W-1:0]  sh_cnt;
    logic [CNT_W-1:0]  inv_cnt;
    logic [WAIT_W-1:0] wait_cnt;
    logic              sh_ok;

    assign sh_ok = (i_rx.header == pcs_pkg::SH_DATA) || (i_rx.header == pcs_pkg::SH_CTRL);

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= UNLOCKED;
            sh_cnt       <= '0;
            inv_cnt      <= '0;
            wait_cnt     <= '0;
            o_block_lock <= 1'b0;
            o_rxslip     <= 1'b0;
        end else begin
            o_rxslip <= 1'b0;
            case (state)
                UNLOCKED: begin
                    if (i_rx.header_valid) begin
                        if (!sh_ok) begin
                            o_rxslip <= 1'b1;
                            sh_cnt   <= '0;
                            wait_cnt <= '0;
                            state    <= SLIP_WAIT_ST;
                        end else if (sh_cnt == SH_LAST) begin
                            // Full run of good headers
                            o_block_lock <= 1'b1;
                            sh_cnt       <= '0;
                            inv_cnt      <= '0;
                            state        <= LOCKED;
                        end else begin
                            sh_cnt <= sh_cnt + 1'b1;
                        end
                    end
                end
                // Give the transceiver time to apply the slip
                SLIP_WAIT_ST: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == WAIT_LAST) begin
                        sh_cnt <= '0;
                        state  <= UNLOCKED;
                    end
                end
                LOCKED: begin
                    if (i_rx.header_valid) begin
                        if (!sh_ok && inv_cnt == INV_LAST) begin
                            // Too many bad headers in this window
                            o_block_lock <= 1'b0;
                            o_rxslip     <= 1'b1;
                            sh_cnt       <= '0;
                            inv_cnt      <= '0;
                            wait_cnt     <= '0;
                            state        <= SLIP_WAIT_ST;
                        end else if (sh_cnt == SH_LAST) begin
                            sh_cnt  <= '0;
                            inv_cnt <= '0;
                        end else begin
                            sh_cnt <= sh_cnt + 1'b1;
                            if (!sh_ok) begin
                                inv_cnt <= inv_cnt + 1'b1;
                            end
                        end
                    end
                end
                default: begin
                    state <= UNLOCKED;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/pcs_pkg.sv ====
`default_nettype none

package pcs_pkg;

    // One transceiver word per clock
    typedef logic [31:0] pcs_word_t;

    // 64b/66b sync header, 01 for data, 10 for control
    typedef logic [1:0] sync_header_t;

    typedef logic [7:0] block_type_t;

    // Scrambler history, newest bit in position 0
    typedef logic [57:0] scr_state_t;

    localparam sync_header_t SH_DATA = 2'b01;
    localparam sync_header_t SH_CTRL = 2'b10;

    // x^39 and x^58 taps of x^58 + x^39 + 1
    localparam int SCR_TAP_A = 38;
    localparam int SCR_TAP_B = 57;

    localparam scr_state_t SCR_SEED = '1;

    // Block type 0x1E bit-reversed into the top byte
    localparam pcs_word_t IDLE_CTRL_WORD = 32'h7800_0000;

    typedef struct packed {
        pcs_word_t    data;
        sync_header_t header;
        logic         data_valid;
        logic         header_valid;
    } pcs_rx_word_t;

    typedef struct packed {
        logic qpll_lock;
        logic rx_reset_done;
        logic tx_reset_done;
    } gt_status_t;

    typedef struct packed {
        logic qpll_reset;
        logic gtx_reset;
        logic userrdy;
        logic tx_seqstart;
    } gt_ctrl_t;

    // One bit through the self-synchronous scrambler
    // Descramble mode shifts the line bit into the history instead of the result
    function automatic logic scr_step(
        input  logic       in_bit,
        input  scr_state_t state,
        input  logic       descramble,
        output scr_state_t next_state
    );
        logic out_bit;
        out_bit = in_bit ^ state[SCR_TAP_A] ^ state[SCR_TAP_B];
        if (descramble) begin
            next_state = {state[56:0], in_bit};
        end else begin
            next_state = {state[56:0], out_bit};
        end
        return out_bit;
    endfunction

endpackage

`default_nettype wire

// ==== source/pcs_reset_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcs_reset_seq (
    input  wire                 clk_gtx_tx,
    input  wire                 i_rst_n,
    input  wire pcs_pkg::gt_status_t i_gt_status,
    output pcs_pkg::gt_ctrl_t   o_gt_ctrl
);

    typedef enum logic [1:0] {
        PLL_RESET,
        GTX_RESET,
        USR_RDY,
        DONE
    } reset_state_t;

    reset_state_t state;

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state                 <= PLL_RESET;
            o_gt_ctrl.qpll_reset  <= 1'b1;
            o_gt_ctrl.gtx_reset   <= 1'b1;
            o_gt_ctrl.userrdy     <= 1'b0;
            o_gt_ctrl.tx_seqstart <= 1'b0;
        end else begin
            case (state)
                // Hold both resets for one cycle
                PLL_RESET: begin
                    o_gt_ctrl.qpll_reset <= 1'b1;
                    o_gt_ctrl.gtx_reset  <= 1'b1;
                    state                <= GTX_RESET;
                end
                // Release the QPLL and wait for lock
                GTX_RESET: begin
                    o_gt_ctrl.qpll_reset <= 1'b0;
                    if (i_gt_status.qpll_lock) begin
                        o_gt_ctrl.gtx_reset <= 1'b0;
                        state               <= USR_RDY;
                    end
                end
                USR_RDY: begin
                    o_gt_ctrl.userrdy <= 1'b1;
                    // Both directions out of reset, start the TX gearbox
                    if (i_gt_status.rx_reset_done && i_gt_status.tx_reset_done) begin
                        o_gt_ctrl.tx_seqstart <= 1'b1;
                        state                 <= DONE;
                    end
                end
                DONE: begin
                    state <= DONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/pcs_rx_descrambler.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_descrambler (
    input  wire                       clk_gtx_tx,
    input  wire                       i_rst_n,
    input  wire pcs_pkg::pcs_rx_word_t i_rx,
    output pcs_pkg::pcs_rx_word_t     o_rx,
    output pcs_pkg::block_type_t      o_block_type
);

    localparam int WORD_W = $bits(pcs_pkg::pcs_word_t);

    pcs_pkg::scr_state_t  scr_state;
    pcs_pkg::scr_state_t  scr_next;
    pcs_pkg::pcs_word_t   descr_word;
    pcs_pkg::block_type_t type_rev;

    // History takes the line bits, so the descrambler self-synchronizes
    always_comb begin : descramble
        pcs_pkg::scr_state_t st;
        pcs_pkg::scr_state_t nxt;
        st = scr_state;
        for (int i = 0; i < WORD_W; i++) begin
            descr_word[i] = pcs_pkg::scr_step(i_rx.data[i], st, 1'b1, nxt);
            st = nxt;
        end
        scr_next = st;
    end

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scr_state <= pcs_pkg::SCR_SEED;
            o_rx      <= '0;
        end else begin
            // Header and strobes stay aligned with their data word
            o_rx.header       <= i_rx.header;
            o_rx.data_valid   <= i_rx.data_valid;
            o_rx.header_valid <= i_rx.header_valid;
            if (i_rx.data_valid) begin
                o_rx.data <= descr_word;
                scr_state <= scr_next;
            end
        end
    end

    // First byte of the block arrives bit-reversed in the top byte
    assign type_rev = {<<{o_rx.data[31:24]}};

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_block_type <= '0;
        end else if (o_rx.header_valid) begin
            if (o_rx.header == pcs_pkg::SH_CTRL) begin
                o_block_type <= type_rev;
            end else if (o_rx.header == pcs_pkg::SH_DATA) begin
                o_block_type <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/pcs_tx_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_path (
    input  wire                clk_gtx_tx,
    input  wire                i_rst_n,
    input  wire                i_tx_gearbox_ready,
    input  wire                i_tx_seqstart,
    output pcs_pkg::pcs_word_t o_tx_data
);

    localparam int WORD_W = $bits(pcs_pkg::pcs_word_t);

    logic                gearbox_ready_q;
    logic                tx_ready;
    logic                toggle;
    pcs_pkg::pcs_word_t  pattern;
    pcs_pkg::pcs_word_t  scr_word;
    pcs_pkg::scr_state_t scr_state;
    pcs_pkg::scr_state_t scr_next;

    // Gearbox ready stretched by one cycle, only after sequence start
    assign tx_ready = (i_tx_gearbox_ready | gearbox_ready_q) & i_tx_seqstart;

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gearbox_ready_q <= 1'b0;
        end else begin
            gearbox_ready_q <= i_tx_gearbox_ready;
        end
    end

    // Alternate the idle control word and an all zero word
    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            toggle  <= 1'b0;
            pattern <= '0;
        end else if (tx_ready) begin
            toggle <= ~toggle;
            if (toggle) begin
                pattern <= '0;
            end else begin
                pattern <= pcs_pkg::IDLE_CTRL_WORD;
            end
        end
    end

    // Bit 0 goes through the scrambler first
    always_comb begin : scramble
        pcs_pkg::scr_state_t st;
        pcs_pkg::scr_state_t nxt;
        st = scr_state;
        for (int i = 0; i < WORD_W; i++) begin
            scr_word[i] = pcs_pkg::scr_step(pattern[i], st, 1'b0, nxt);
            st = nxt;
        end
        scr_next = st;
    end

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scr_state <= pcs_pkg::SCR_SEED;
            o_tx_data <= '0;
        end else if (tx_ready) begin
            scr_state <= scr_next;
            o_tx_data <= scr_word;
        end
    end

endmodule

`default_nettype wire

// ==== tests/eth_10g_pcs_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_10g_pcs_assert (
    input wire                    clk_gtx_tx,
    input wire                    i_rst_n,
    input wire pcs_pkg::gt_ctrl_t i_gt_ctrl,
    input wire                    i_rxslip
);

    // Number of failed assertions so far
    int fail_count = 0;

    // A slip request is a single-cycle pulse
    slip_single: assert property (@(posedge clk_gtx_tx) disable iff (!i_rst_n)
        i_rxslip |=> !i_rxslip)
        else begin
            fail_count++;
            $error("o_rxslip high for two cycles in a row");
        end

    userrdy_after_gtx: assert property (@(posedge clk_gtx_tx) disable iff (!i_rst_n)
        i_gt_ctrl.userrdy |-> !i_gt_ctrl.gtx_reset)
        else begin
            fail_count++;
            $error("userrdy high while gtx_reset is still asserted");
        end

    seqstart_after_userrdy: assert property (@(posedge clk_gtx_tx) disable iff (!i_rst_n)
        i_gt_ctrl.tx_seqstart |-> i_gt_ctrl.userrdy)
        else begin
            fail_count++;
            $error("tx_seqstart high without userrdy");
        end

endmodule

bind eth_10g_pcs_top eth_10g_pcs_assert assert_u (
    .clk_gtx_tx (clk_gtx_tx),
    .i_rst_n    (i_rst_n),
    .i_gt_ctrl  (o_gt_ctrl),
    .i_rxslip   (o_rxslip)
);

`default_nettype wire

// ==== tests/eth_10g_pcs_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_10g_pcs_tb;

    localparam int LOCK_COUNT    = 8;
    localparam int INVALID_LIMIT = 4;
    localparam int SLIP_WAIT     = 6;

    // Lock model states
    localparam int L_UNLOCKED = 0;
    localparam int L_WAIT     = 1;
    localparam int L_LOCKED   = 2;

    logic                  clk_gtx_tx;
    logic                  i_rst_n;
    logic                  i_tx_gearbox_ready;
    pcs_pkg::gt_status_t   i_gt_status;
    pcs_pkg::pcs_rx_word_t i_rx;
    pcs_pkg::gt_ctrl_t     o_gt_ctrl;
    pcs_pkg::pcs_word_t    o_tx_data;
    pcs_pkg::pcs_rx_word_t o_rx;
    pcs_pkg::block_type_t  o_block_type;
    logic                  o_block_lock;
    logic                  o_rxslip;

    logic [31:0]         rng;
    int                  err_count;
    int                  cyc;
    int                  d_lock;
    int                  d_rx;
    int                  d_tx;
    int                  n_valid;
    pcs_pkg::scr_state_t line_scr;
    pcs_pkg::pcs_word_t  orig_q;

    // Reference model state
    int                    m_seq;
    pcs_pkg::gt_ctrl_t     m_ctrl;
    logic                  m_gb_q;
    logic                  m_toggle;
    pcs_pkg::pcs_word_t    m_pattern;
    pcs_pkg::pcs_word_t    m_tx;
    pcs_pkg::scr_state_t   m_tx_scr;
    pcs_pkg::scr_state_t   m_rx_scr;
    pcs_pkg::pcs_rx_word_t m_rx;
    pcs_pkg::block_type_t  m_btype;
    int                    m_lst;
    int                    m_sh;
    int                    m_inv;
    int                    m_wait;
    logic                  m_lock;
    logic                  m_slip;

    eth_10g_pcs_top #(
        .LOCK_COUNT    (LOCK_COUNT),
        .INVALID_LIMIT (INVALID_LIMIT),
        .SLIP_WAIT     (SLIP_WAIT)
    ) uut (
        .clk_gtx_tx         (clk_gtx_tx),
        .i_rst_n            (i_rst_n),
        .i_gt_status        (i_gt_status),
        .o_gt_ctrl          (o_gt_ctrl),
        .i_tx_gearbox_ready (i_tx_gearbox_ready),
        .o_tx_data          (o_tx_data),
        .i_rx               (i_rx),
        .o_rx               (o_rx),
        .o_block_type       (o_block_type),
        .o_block_lock       (o_block_lock),
        .o_rxslip           (o_rxslip)
    );

    initial begin
        clk_gtx_tx = 1'b0;
        forever #4 clk_gtx_tx = ~clk_gtx_tx;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic pcs_pkg::block_type_t reverse_byte(input logic [7:0] b);
        pcs_pkg::block_type_t r;
        for (int i = 0; i < 8; i++) begin
            r[7 - i] = b[i];
        end
        return r;
    endfunction

    // x^58 + x^39 + 1 with bit 0 first and the line bit into the history
    task automatic scramble_word(input pcs_pkg::pcs_word_t w, input logic descr,
                                 inout pcs_pkg::scr_state_t s, output pcs_pkg::pcs_word_t y);
        logic b;
        for (int i = 0; i < 32; i++) begin
            b = w[i] ^ s[pcs_pkg::SCR_TAP_A] ^ s[pcs_pkg::SCR_TAP_B];
            y[i] = b;
            s = {s[56:0], descr ? w[i] : b};
        end
    endtask

    task automatic fail_run(input string what);
        err_count++;
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input pcs_pkg::pcs_word_t got,
                              input pcs_pkg::pcs_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_block_type(input string name, input pcs_pkg::block_type_t got,
                                    input pcs_pkg::block_type_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_ctrl(input string name, input pcs_pkg::gt_ctrl_t got,
                              input pcs_pkg::gt_ctrl_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic init_model();
        m_seq     = 0;
        m_ctrl    = 4'b1100;
        m_gb_q    = 1'b0;
        m_toggle  = 1'b0;
        m_pattern = '0;
        m_tx      = '0;
        m_tx_scr  = pcs_pkg::SCR_SEED;
        m_rx_scr  = pcs_pkg::SCR_SEED;
        m_rx      = '0;
        m_btype   = '0;
        m_lst     = L_UNLOCKED;
        m_sh      = 0;
        m_inv     = 0;
        m_wait    = 0;
        m_lock    = 1'b0;
        m_slip    = 1'b0;
    endtask

    // One clock edge of every model from pre-edge model state
    task automatic step_model();
        logic qrdy;
        logic ok;
        qrdy = (i_tx_gearbox_ready | m_gb_q) & m_ctrl.tx_seqstart;
        m_gb_q = i_tx_gearbox_ready;
        if (qrdy) begin
            scramble_word(m_pattern, 1'b0, m_tx_scr, m_tx);
            m_pattern = m_toggle ? '0 : pcs_pkg::IDLE_CTRL_WORD;
            m_toggle = ~m_toggle;
        end
        // Sequencer states 0 PLL reset, 1 GTX reset, 2 user ready and 3 done
        case (m_seq)
            0: begin
                m_seq = 1;
            end
            1: begin
                m_ctrl.qpll_reset = 1'b0;
                if (i_gt_status.qpll_lock) begin
                    m_ctrl.gtx_reset = 1'b0;
                    m_seq = 2;
                end
            end
            2: begin
                m_ctrl.userrdy = 1'b1;
                if (i_gt_status.rx_reset_done && i_gt_status.tx_reset_done) begin
                    m_ctrl.tx_seqstart = 1'b1;
                    m_seq = 3;
                end
            end
            default: begin
            end
        endcase
        // Type byte comes from the word already on o_rx
        if (m_rx.header_valid && m_rx.header == pcs_pkg::SH_CTRL) begin
            m_btype = reverse_byte(m_rx.data[31:24]);
        end else if (m_rx.header_valid && m_rx.header == pcs_pkg::SH_DATA) begin
            m_btype = '0;
        end
        m_rx.header       = i_rx.header;
        m_rx.data_valid   = i_rx.data_valid;
        m_rx.header_valid = i_rx.header_valid;
        if (i_rx.data_valid) begin
            scramble_word(i_rx.data, 1'b1, m_rx_scr, m_rx.data);
        end
        ok = (i_rx.header == pcs_pkg::SH_DATA) || (i_rx.header == pcs_pkg::SH_CTRL);
        m_slip = 1'b0;
        if (m_lst == L_WAIT) begin
            if (m_wait == SLIP_WAIT - 1) begin
                m_lst = L_UNLOCKED;
                m_sh  = 0;
            end
            m_wait++;
        end else if (i_rx.header_valid && !ok &&
                     (m_lst == L_UNLOCKED || m_inv == INVALID_LIMIT - 1)) begin
            m_slip = 1'b1;
            m_lock = 1'b0;
            m_lst  = L_WAIT;
            m_wait = 0;
            m_sh   = 0;
            m_inv  = 0;
        end else if (i_rx.header_valid && m_sh == LOCK_COUNT - 1) begin
            // Run complete while unlocked or window complete while locked
            m_lock = 1'b1;
            m_lst  = L_LOCKED;
            m_sh   = 0;
            m_inv  = 0;
        end else if (i_rx.header_valid) begin
            m_sh++;
            if (!ok) begin
                m_inv++;
            end
        end
    endtask

    task automatic check_outputs();
        check_ctrl("o_gt_ctrl", o_gt_ctrl, m_ctrl);
        check_word("o_tx_data", o_tx_data, m_tx);
        check_word("o_rx.data", o_rx.data, m_rx.data);
        check_bit("o_rx.header[1]", o_rx.header[1], m_rx.header[1]);
        check_bit("o_rx.header[0]", o_rx.header[0], m_rx.header[0]);
        check_bit("o_rx.data_valid", o_rx.data_valid, m_rx.data_valid);
        check_bit("o_rx.header_valid", o_rx.header_valid, m_rx.header_valid);
        check_block_type("o_block_type", o_block_type, m_btype);
        check_bit("o_block_lock", o_block_lock, m_lock);
        check_bit("o_rxslip", o_rxslip, m_slip);
        // Descrambler has synchronized after two words
        if (n_valid > 2) begin
            check_word("o_rx.data against sent word", o_rx.data, orig_q);
        end
    endtask

    // Header modes 0 idle, 1 random, 2 all good and 3 all invalid
    task automatic run_cycle(input int hmode);
        logic [31:0]           r;
        logic                  vld;
        pcs_pkg::sync_header_t hdr;
        pcs_pkg::pcs_word_t    orig;
        pcs_pkg::pcs_word_t    line;
        r = next_rand();
        case (hmode)
            1: begin
                vld = (r[3:2] != 2'b00);
                hdr = r[9] ? pcs_pkg::SH_CTRL : pcs_pkg::SH_DATA;
                if (r[7:4] == 4'd0) begin
                    hdr = {r[8], r[8]};
                end
            end
            2: begin
                vld = 1'b1;
                hdr = r[9] ? pcs_pkg::SH_CTRL : pcs_pkg::SH_DATA;
            end
            3: begin
                vld = 1'b1;
                hdr = {r[8], r[8]};
            end
            default: begin
                vld = 1'b0;
                hdr = '0;
            end
        endcase
        orig = next_rand();
        line = next_rand();
        if (vld) begin
            scramble_word(orig, 1'b0, line_scr, line);
            orig_q = orig;
            n_valid++;
        end
        i_tx_gearbox_ready        = r[0];
        i_gt_status.qpll_lock     = (cyc >= d_lock);
        i_gt_status.rx_reset_done = (cyc >= d_rx);
        i_gt_status.tx_reset_done = (cyc >= d_tx);
        i_rx.data                 = line;
        i_rx.header               = hdr;
        i_rx.data_valid           = vld;
        i_rx.header_valid         = vld;
        step_model();
        cyc++;
        @(negedge clk_gtx_tx);
        check_outputs();
    endtask

    // A failed protocol assertion in the bound checker also ends the run
    always @(uut.assert_u.fail_count) begin
        if (uut.assert_u.fail_count != 0) begin
            fail_run("a protocol assertion in the bound checker failed");
        end
    end

    initial begin
        #100000;
        fail_run("simulation time limit reached before the test finished");
    end

    initial begin
        int n;
        int slips;
        rng                = 32'd38;
        i_rst_n            = 1'b0;
        i_tx_gearbox_ready = 1'b0;
        i_gt_status        = '0;
        i_rx               = '0;
        err_count          = 0;
        cyc                = 0;
        n_valid            = 0;
        line_scr           = pcs_pkg::SCR_SEED;
        orig_q             = '0;
        d_lock             = 2 + int'(next_rand() % 10);
        d_rx               = d_lock + 1 + int'(next_rand() % 8);
        d_tx               = d_lock + 1 + int'(next_rand() % 8);
        init_model();
        repeat (5) @(posedge clk_gtx_tx);
        @(negedge clk_gtx_tx);
        i_rst_n = 1'b1;

        // Reset sequence up to TX sequence start
        for (n = 0; n < 100 && o_gt_ctrl.tx_seqstart !== 1'b1; n++) begin
            run_cycle(0);
        end
        if (o_gt_ctrl.tx_seqstart !== 1'b1) begin
            fail_run("timeout waiting for tx_seqstart after the reset sequence");
        end

        // Random TX ready and RX words with gaps and mixed headers
        repeat (400) run_cycle(1);

        for (n = 0; n < 40 && o_block_lock !== 1'b1; n++) begin
            run_cycle(2);
        end
        if (o_block_lock !== 1'b1) begin
            fail_run("timeout waiting for block lock on good headers");
        end

        for (n = 0; n < 20 && o_block_lock !== 1'b0; n++) begin
            run_cycle(3);
        end
        if (o_block_lock !== 1'b0) begin
            fail_run("timeout waiting for block lock to drop on invalid headers");
        end
        check_bit("o_rxslip at lock loss", o_rxslip, 1'b1);

        // One slip per invalid header while unlocked plus the ignored wait
        slips = 0;
        repeat (3 * (SLIP_WAIT + 1)) begin
            run_cycle(3);
            if (o_rxslip === 1'b1) begin
                slips++;
            end
        end
        if (slips != 3) begin
            fail_run($sformatf("expected 3 slip pulses while unlocked, saw %0d", slips));
        end

        for (n = 0; n < 40 && o_block_lock !== 1'b1; n++) begin
            run_cycle(2);
        end
        if (o_block_lock !== 1'b1) begin
            fail_run("timeout waiting for block lock to return");
        end

        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
